// ==== include/bp_defines.svh ====
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// global history length in bits
`define GH_WIDTH 10

// pattern table index width, the table holds 2**PHT_IDX_WIDTH counters
// kept equal to GH_WIDTH so the gshare hash is a plain xor
`define PHT_IDX_WIDTH 10

// unresolved branches allowed in flight
`define QUEUE_LEN 8

// fetch address width
`define PC_WIDTH 32

`endif

// ==== hw/bp_pkg.sv ====
`include "bp_defines.svh"

package bp_pkg;

    // speculative global history, newest outcome in bit 0
    typedef logic [`GH_WIDTH-1:0] ghist_t;

    // pattern table index
    typedef logic [`PHT_IDX_WIDTH-1:0] pht_idx_t;

    // fetch address
    typedef logic [`PC_WIDTH-1:0] pc_t;

    // 2-bit saturating counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strongly_not_taken = 2'b00,
        weakly_not_taken   = 2'b01,
        weakly_taken       = 2'b10,
        strongly_taken     = 2'b11
    } ctr_t;

    // counts 0 to QUEUE_LEN inclusive
    typedef logic [$clog2(`QUEUE_LEN + 1)-1:0] qcount_t;

endpackage

// ==== hw/pht.sv ====
`include "bp_defines.svh"

module pht
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  pc_t      predict_pc,
    input  ghist_t   ghist,
    input  logic     upd_valid,
    input  pht_idx_t upd_idx,
    input  logic     upd_taken,
    output pht_idx_t pred_idx,
    output logic     pred_taken
);

    localparam int unsigned PHT_ENTRIES = 1 << `PHT_IDX_WIDTH;

    ctr_t ctr_q [PHT_ENTRIES];
    ctr_t upd_cur;
    ctr_t upd_next;

    // gshare hash, word aligned pc xor history
    assign pred_idx   = predict_pc[`PHT_IDX_WIDTH+1:2] ^ ghist;
    assign pred_taken = ctr_q[pred_idx][1];

    assign upd_cur = ctr_q[upd_idx];

    // one step toward the actual outcome, saturating
    always_comb begin
        upd_next = upd_cur;
        if (upd_taken) begin
            case (upd_cur)
                strongly_not_taken: upd_next = weakly_not_taken;
                weakly_not_taken:   upd_next = weakly_taken;
                weakly_taken:       upd_next = strongly_taken;
                default:            upd_next = strongly_taken;
            endcase
        end else begin
            case (upd_cur)
                strongly_taken:     upd_next = weakly_taken;
                weakly_taken:       upd_next = weakly_not_taken;
                weakly_not_taken:   upd_next = strongly_not_taken;
                default:            upd_next = strongly_not_taken;
            endcase
        end
    end

    // all counters start weakly not taken
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= weakly_not_taken;
            end
        end else if (upd_valid) begin
            ctr_q[upd_idx] <= upd_next;
        end
    end

    // the training index comes from the in-flight queue head
    a_upd_idx_known: assert property (
        @(posedge clk) disable iff (!rstn)
        upd_valid |-> !$isunknown(upd_idx)
    ) else $error("pht: training index unknown");

endmodule

// ==== hw/ghr.sv ====
`include "bp_defines.svh"

module ghr
    import bp_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   predict_valid,
    input  logic   pred_taken,
    input  logic   resolve_valid,
    input  logic   mispredict,
    output ghist_t ghist
);

    localparam int PTR_W = $clog2(`QUEUE_LEN);

    logic             restore;
    logic             shift_in;
    ghist_t           ghist_next;
    qcount_t          live_cnt;
    logic [PTR_W-1:0] oldest_pos;
    ghist_t           chkpt_q [`QUEUE_LEN];

    assign restore    = resolve_valid && mispredict;
    // a predict next to a mispredicting resolve is squashed
    assign shift_in   = predict_valid && !restore;
    assign ghist_next = {ghist[`GH_WIDTH-2:0], pred_taken};
    assign oldest_pos = PTR_W'(live_cnt - qcount_t'(1));

    // each checkpoint already holds the corrected outcome of its branch
    always_ff @(posedge clk) begin
        if (shift_in) begin
            chkpt_q[0] <= {ghist[`GH_WIDTH-2:0], ~pred_taken};
            for (int i = 1; i < `QUEUE_LEN; i++) begin
                chkpt_q[i] <= chkpt_q[i-1];
            end
        end
    end

    // live checkpoints, the oldest sits at live_cnt - 1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            live_cnt <= '0;
        end else if (restore) begin
            live_cnt <= '0;
        end else if (shift_in && !resolve_valid) begin
            live_cnt <= live_cnt + qcount_t'(1);
        end else if (resolve_valid && !shift_in) begin
            live_cnt <= live_cnt - qcount_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ghist <= '0;
        end else if (restore) begin
            ghist <= chkpt_q[oldest_pos];
        end else if (shift_in) begin
            ghist <= ghist_next;
        end
    end

    // holds only while fetch honours the queue full flag
    a_live_cnt_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        live_cnt <= qcount_t'(`QUEUE_LEN)
    ) else $error("ghr: live checkpoint count above queue length");

endmodule

// ==== hw/inflight_queue.sv ====
`include "bp_defines.svh"

module inflight_queue
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     predict_valid,
    input  pht_idx_t pred_idx,
    input  logic     pred_taken,
    input  logic     resolve_valid,
    input  logic     resolve_taken,
    output logic     mispredict,
    output logic     full,
    output logic     upd_valid,
    output pht_idx_t upd_idx,
    output logic     upd_taken
);

    localparam int PTR_W = $clog2(`QUEUE_LEN);

    pht_idx_t         idx_q   [`QUEUE_LEN];
    logic             taken_q [`QUEUE_LEN];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    qcount_t          cnt_q;
    logic             push;
    logic             flush_all;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(`QUEUE_LEN - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    assign full      = (cnt_q == qcount_t'(`QUEUE_LEN));
    // compare against the oldest stored guess
    assign flush_all = resolve_valid && (taken_q[head_q] != resolve_taken);
    assign mispredict = flush_all;
    assign push      = predict_valid && !full && !flush_all;

    assign upd_valid = resolve_valid;
    assign upd_idx   = idx_q[head_q];
    assign upd_taken = resolve_taken;

    always_ff @(posedge clk) begin
        if (push) begin
            idx_q[tail_q]   <= pred_idx;
            taken_q[tail_q] <= pred_taken;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (flush_all) begin
            // younger branches are squashed along with the head
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (resolve_valid) begin
                head_q <= ptr_inc(head_q);
            end
            if (push && !resolve_valid) begin
                cnt_q <= cnt_q + qcount_t'(1);
            end else if (resolve_valid && !push) begin
                cnt_q <= cnt_q - qcount_t'(1);
            end
        end
    end

    // branches resolve in order, never more than were predicted
    a_no_resolve_empty: assert property (
        @(posedge clk) disable iff (!rstn)
        resolve_valid |-> (cnt_q != '0)
    ) else $error("inflight_queue: resolve with nothing in flight");

    // fetch must stall on full, or the history would shift without a queue entry
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rstn)
        (predict_valid && !flush_all) |-> !full
    ) else $error("inflight_queue: predict issued while full");

endmodule

// ==== hw/gshare_top.sv ====
module gshare_top
    import bp_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   predict_valid,
    input  pc_t    predict_pc,
    output logic   pred_taken,
    input  logic   resolve_valid,
    input  logic   resolve_taken,
    output logic   mispredict,
    output logic   full,
    output ghist_t ghist
);

    pht_idx_t pred_idx;
    logic     upd_valid;
    pht_idx_t upd_idx;
    logic     upd_taken;

    // index hash and counter table
    pht u_pht (
        .clk        (clk),
        .rstn       (rstn),
        .predict_pc (predict_pc),
        .ghist      (ghist),
        .upd_valid  (upd_valid),
        .upd_idx    (upd_idx),
        .upd_taken  (upd_taken),
        .pred_idx   (pred_idx),
        .pred_taken (pred_taken)
    );

    // speculative history with restore checkpoints
    ghr u_ghr (
        .clk           (clk),
        .rstn          (rstn),
        .predict_valid (predict_valid),
        .pred_taken    (pred_taken),
        .resolve_valid (resolve_valid),
        .mispredict    (mispredict),
        .ghist         (ghist)
    );

    // unresolved branches and mispredict detection
    inflight_queue u_inflight_queue (
        .clk           (clk),
        .rstn          (rstn),
        .predict_valid (predict_valid),
        .pred_idx      (pred_idx),
        .pred_taken    (pred_taken),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .mispredict    (mispredict),
        .full          (full),
        .upd_valid     (upd_valid),
        .upd_idx       (upd_idx),
        .upd_taken     (upd_taken)
    );

endmodule

// ==== tb/gshare_tb.sv ====
`include "bp_defines.svh"

module gshare_tb
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD  = 4;
    localparam int    RESET_CYCLES = 16;
    localparam string TRACE_FILE  = "tb/gshare_trace.txt";

    logic   clk;
    logic   rstn;
    logic   predict_valid;
    pc_t    predict_pc;
    logic   pred_taken;
    logic   resolve_valid;
    logic   resolve_taken;
    logic   mispredict;
    logic   full;
    ghist_t ghist;

    // one entry per trace line holding the inputs and the expected outputs
    logic   tr_predict_valid [$];
    pc_t    tr_predict_pc    [$];
    logic   tr_resolve_valid [$];
    logic   tr_resolve_taken [$];
    logic   tr_pred_taken    [$];
    logic   tr_mispredict    [$];
    logic   tr_full          [$];
    ghist_t tr_ghist         [$];

    int n_lines;
    int cycle_no;
    bit trace_loaded;

    gshare_top uut (
        .clk           (clk),
        .rstn          (rstn),
        .predict_valid (predict_valid),
        .predict_pc    (predict_pc),
        .pred_taken    (pred_taken),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .mispredict    (mispredict),
        .full          (full),
        .ghist         (ghist)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_trace();
        int          fd;
        int          n_fields;
        string       line;
        logic [31:0] f_pv;
        logic [31:0] f_pc;
        logic [31:0] f_rv;
        logic [31:0] f_rt;
        logic [31:0] f_pt;
        logic [31:0] f_mp;
        logic [31:0] f_fu;
        logic [31:0] f_gh;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "trace file %s could not be opened", TRACE_FILE);
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                               f_pv, f_pc, f_rv, f_rt, f_pt, f_mp, f_fu, f_gh);
            // blank lines carry no fields
            if (n_fields <= 0) begin
                continue;
            end
            if (n_fields != 8) begin
                $display("CHECKS FAILED");
                $fatal(1, "trace line %0d has %0d fields instead of 8", n_lines + 1, n_fields);
            end
            tr_predict_valid.push_back(f_pv[0]);
            tr_predict_pc.push_back(f_pc);
            tr_resolve_valid.push_back(f_rv[0]);
            tr_resolve_taken.push_back(f_rt[0]);
            tr_pred_taken.push_back(f_pt[0]);
            tr_mispredict.push_back(f_mp[0]);
            tr_full.push_back(f_fu[0]);
            tr_ghist.push_back(f_gh[`GH_WIDTH-1:0]);
            n_lines++;
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "trace file %s holds no cycles", TRACE_FILE);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED cycle %0d: %s expected 0x%0h got 0x%0h",
                     cycle_no, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic drive_cycle(input int i);
        predict_valid = tr_predict_valid[i];
        predict_pc    = tr_predict_pc[i];
        resolve_valid = tr_resolve_valid[i];
        resolve_taken = tr_resolve_taken[i];
    endtask

    task automatic check_cycle(input int i);
        // the guess only matters on a predict cycle
        if (tr_predict_valid[i]) begin
            check_value("pred_taken", 32'(tr_pred_taken[i]), 32'(pred_taken));
        end
        check_value("mispredict", 32'(tr_mispredict[i]), 32'(mispredict));
        check_value("full", 32'(tr_full[i]), 32'(full));
        check_value("ghist", 32'(tr_ghist[i]), 32'(ghist));
    endtask

    initial begin
        rstn          = 1'b0;
        predict_valid = 1'b0;
        predict_pc    = '0;
        resolve_valid = 1'b0;
        resolve_taken = 1'b0;
        n_lines       = 0;
        cycle_no      = 0;
        load_trace();
        trace_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rstn = 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            #0.5;
            cycle_no = i + 1;
            drive_cycle(i);
            // sample 1 ns ahead of the next rising edge
            #(CLK_PERIOD - 1.5);
            check_cycle(i);
        end

        $display("%0d trace cycles checked", n_lines);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // bound the run by the trace length plus reset and some margin
    initial begin
        wait (trace_loaded);
        #((n_lines + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired before the trace was finished");
    end

endmodule

// ==== tb/gshare_trace.txt ====
# columns: predict_valid predict_pc resolve_valid resolve_taken | expected pred_taken mispredict full ghist
# all hex, one line per clock cycle, pred_taken is compared only when predict_valid is 1
0 00000000 0 0 0 0 0 000
1 00000100 0 0 0 0 0 000
1 00000104 0 0 0 0 0 000
0 00000000 1 0 0 0 0 000
0 00000000 1 0 0 0 0 000
1 00000200 0 0 0 0 0 000
0 00000000 1 1 0 1 0 000
1 00000204 0 0 1 0 0 001
0 00000000 1 1 0 0 0 003
1 0000020c 0 0 1 0 0 003
0 00000000 1 1 0 0 0 007
1 0000021c 0 0 1 0 0 007
0 00000000 1 0 0 1 0 00f
1 00000238 0 0 1 0 0 00e
0 00000000 1 1 0 0 0 01d
1 00000400 0 0 0 0 0 01d
1 00000404 0 0 0 0 0 03a
1 000003d0 0 0 1 0 0 074
0 00000000 1 1 0 1 0 0e9
0 00000000 0 0 0 0 0 03b
1 00000040 0 0 0 0 0 03b
1 00000044 1 0 0 0 0 076
1 00000048 1 1 0 1 0 0ec
0 00000000 0 0 0 0 0 0ed
1 00000000 0 0 0 0 0 0ed
1 00000000 0 0 0 0 0 1da
1 00000000 0 0 0 0 0 3b4
1 00000000 0 0 0 0 0 368
1 00000000 0 0 0 0 0 2d0
1 00000000 0 0 0 0 0 1a0
1 00000000 0 0 0 0 0 340
1 00000000 0 0 0 0 0 280
0 00000000 0 0 0 0 1 100
0 00000000 1 0 0 0 1 100
0 00000000 0 0 0 0 0 100
0 00000000 1 1 0 1 0 100
1 00000cd4 0 0 1 0 0 3b5
1 00000cd4 0 0 0 0 0 36b
0 00000000 1 1 0 0 0 2d6
0 00000000 1 1 0 1 0 2d6
1 00000a24 0 0 1 0 0 2d7
1 000004bc 0 0 1 0 0 1af
0 00000000 1 1 0 0 0 35f
0 00000000 1 1 0 0 0 35f
1 0000057c 0 0 0 0 0 35f
1 000002f8 1 1 0 1 0 2be
1 000002fc 0 0 1 0 0 2bf
0 00000000 1 1 0 0 0 17f
0 00000000 0 0 0 0 0 17f

// ==== vlog.f ====
+incdir+include
hw/bp_pkg.sv
hw/pht.sv
hw/ghr.sv
hw/inflight_queue.sv
hw/gshare_top.sv
tb/gshare_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module gshare_tb \
    -f vlog.f -o gshare_sim \
    && ./obj_dir/gshare_sim \
    || { echo "simulation failed"; exit 1; }
